/* ecl_defines.svh */
`ifndef ECL_DEFINES_SVH
`define ECL_DEFINES_SVH

// general register width
`define ECL_GRLEN 32

// register number width
`define ECL_RA_BITS 5

// csr address width
`define ECL_CSR_BITS 14

`endif

/* ecl_pkg.sv */
`include "ecl_defines.svh"

package ecl_pkg;

   typedef logic [`ECL_GRLEN-1:0]    word_t;
   typedef logic [`ECL_RA_BITS-1:0]  reg_addr_t;
   typedef logic [`ECL_CSR_BITS-1:0] csr_addr_t;

   // control of the instruction sitting in e
   typedef struct packed {
      logic      valid;
      reg_addr_t rs1;
      reg_addr_t rs2;
      reg_addr_t rf_target;
      logic      alu_wen;
      logic      b_imm;
      logic      double_read;
      logic      lsu_valid;
      logic      mul_valid;
      logic      mul_wen;
      logic      csr_valid;
      logic      csr_rdwen;
      logic      csr_xchg;
      logic      csr_wen;
      csr_addr_t csr_waddr;
   } issue_t;

   // lsu result arriving late at m
   typedef struct packed {
      word_t     rdata;
      logic      finish;
      reg_addr_t rd;
      logic      wen;
   } lsu_ret_t;

   typedef struct packed {
      logic      wen;
      csr_addr_t waddr;
      word_t     wdata;
      word_t     mask;
   } csr_wr_t;

   // register write used at m for forwarding and at w for the regfile
   typedef struct packed {
      logic      wen;
      reg_addr_t rd;
      word_t     data;
   } rf_wr_t;

endpackage

/* ecl_bypass.sv */
`timescale 1ns/1ps

module ecl_bypass (
   input  ecl_pkg::issue_t issue,
   input  ecl_pkg::word_t  alu_a_raw,
   input  ecl_pkg::word_t  alu_b_raw,
   input  ecl_pkg::word_t  imm_shifted,
   input  ecl_pkg::rf_wr_t fwd_m,
   input  ecl_pkg::rf_wr_t fwd_w,
   output ecl_pkg::word_t  rs1_data,
   output ecl_pkg::word_t  rs2_data,
   output ecl_pkg::word_t  lsu_offset
);

   import ecl_pkg::*;

   logic use_other;

   // m stage wins over w, regfile value last
   function automatic word_t fwd_sel(
      input reg_addr_t rs,
      input word_t     raw,
      input logic      keep_raw,
      input rf_wr_t    m,
      input rf_wr_t    w
   );
      word_t res;
      if (keep_raw) begin
         res = raw;
      end else if (m.wen && (m.rd == rs)) begin
         res = m.data;
      end else if (w.wen && (w.rd == rs)) begin
         res = w.data;
      end else begin
         res = raw;
      end
      return res;
   endfunction

   ////////////////////
   // operand select
   ////////////////////

   // b comes straight from decode for an immediate or an indexed store
   assign use_other = issue.b_imm | issue.double_read;

   always_comb begin
      rs1_data = fwd_sel(issue.rs1, alu_a_raw, 1'b0, fwd_m, fwd_w);
      rs2_data = fwd_sel(issue.rs2, alu_b_raw, use_other, fwd_m, fwd_w);
   end

   ////////////////////
   // lsu offset
   ////////////////////

   // register offset for indexed access
   assign lsu_offset = issue.double_read ? rs2_data : imm_shifted;

endmodule

/* ecl_e2m_regs.sv */
`timescale 1ns/1ps

module ecl_e2m_regs (
   input  logic             clk,
   input  logic             rst,
   input  ecl_pkg::issue_t  issue,
   input  logic             kill,
   input  ecl_pkg::word_t   rs1_data,
   input  ecl_pkg::word_t   rs2_data,
   input  ecl_pkg::word_t   alu_res_e,
   input  ecl_pkg::word_t   csr_rdata_d,
   output ecl_pkg::rf_wr_t  alu_m,
   output logic             mul_valid_m,
   output logic             mul_wen_m,
   output logic             csr_valid_m,
   output logic             csr_rdwen_m,
   output ecl_pkg::word_t   csr_rdata_m,
   output ecl_pkg::csr_wr_t csr_wr
);

   import ecl_pkg::*;

   logic  alu_wen_e;
   logic  mul_valid_e;
   logic  csr_valid_e;
   word_t csr_mask_e;
   word_t csr_rdata_e;

   // killed instruction must not claim any unit
   assign alu_wen_e   = issue.alu_wen & ~kill;
   assign mul_valid_e = issue.mul_valid & ~kill;
   assign csr_valid_e = issue.csr_valid & ~kill;

   // plain csrwr behaves as an exchange with a full mask
   assign csr_mask_e = issue.csr_xchg ? rs1_data : '1;

   ////////////////////
   // control bits
   ////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         alu_m.wen   <= 1'b0;
         mul_valid_m <= 1'b0;
         mul_wen_m   <= 1'b0;
         csr_valid_m <= 1'b0;
         csr_rdwen_m <= 1'b0;
         csr_wr.wen  <= 1'b0;
      end else begin
         alu_m.wen   <= alu_wen_e;
         mul_valid_m <= mul_valid_e;
         mul_wen_m   <= issue.mul_wen;
         csr_valid_m <= csr_valid_e;
         csr_rdwen_m <= issue.csr_rdwen;
         csr_wr.wen  <= issue.csr_wen;
      end
   end

   ////////////////////
   // payload
   ////////////////////

   always_ff @(posedge clk) begin
      alu_m.rd     <= issue.rf_target;
      alu_m.data   <= alu_res_e;
      csr_wr.waddr <= issue.csr_waddr;
      csr_wr.wdata <= rs2_data;
      csr_wr.mask  <= csr_mask_e;
   end

   // csr read data is sampled at d, two stages to m
   always_ff @(posedge clk) begin
      csr_rdata_e <= csr_rdata_d;
      csr_rdata_m <= csr_rdata_e;
   end

   // stall holds the issue stage so csr writes never come back to back
   assert property (@(posedge clk) disable iff (rst)
      csr_wr.wen |=> !csr_wr.wen);

endmodule

/* ecl_writeback.sv */
`timescale 1ns/1ps

module ecl_writeback (
   input  logic              clk,
   input  logic              rst,
   input  ecl_pkg::rf_wr_t   alu_m,
   input  logic              mul_valid_m,
   input  logic              mul_wen_m,
   input  logic              csr_valid_m,
   input  logic              csr_rdwen_m,
   input  ecl_pkg::word_t    csr_rdata_m,
   input  ecl_pkg::word_t    mul_res_m,
   input  ecl_pkg::lsu_ret_t lsu_ret,
   output ecl_pkg::rf_wr_t   fwd_m,
   output ecl_pkg::rf_wr_t   irf_wr
);

   import ecl_pkg::*;

   word_t     data_m;
   reg_addr_t rd_m;
   logic      wen_m;

   ////////////////////
   // m stage select
   ////////////////////

   // lsu is not in step with the pipe, so it keeps its own rd
   assign rd_m = lsu_ret.finish ? lsu_ret.rd : alu_m.rd;

   // any unit may claim the write
   assign wen_m = alu_m.wen | mul_wen_m | csr_rdwen_m | (lsu_ret.wen & lsu_ret.finish);

   // alu is the default
   always_comb begin
      if (lsu_ret.finish) begin
         data_m = lsu_ret.rdata;
      end else if (mul_valid_m) begin
         data_m = mul_res_m;
      end else if (csr_valid_m) begin
         data_m = csr_rdata_m;
      end else begin
         data_m = alu_m.data;
      end
   end

   assign fwd_m = '{wen: wen_m, rd: rd_m, data: data_m};

   ////////////////////
   // m to w
   ////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         irf_wr.wen <= 1'b0;
      end else begin
         irf_wr.wen <= wen_m;
      end
   end

   always_ff @(posedge clk) begin
      irf_wr.rd   <= rd_m;
      irf_wr.data <= data_m;
   end

   // issue stage keeps the m slot free for a returning load
   assert property (@(posedge clk) disable iff (rst)
      $onehot0({lsu_ret.finish, mul_valid_m, csr_valid_m}));

endmodule

/* ecl_stall_intr.sv */
`timescale 1ns/1ps

module ecl_stall_intr (
   input  logic            clk,
   input  logic            rst,
   input  ecl_pkg::issue_t issue,
   input  logic            csr_wen_m,
   input  logic            lsu_finish,
   input  logic            timer_intr,
   output logic            lsu_valid_e,
   output logic            kill,
   output logic            except,
   output logic            stall_req
);

   logic lsu_stall;
   logic lsu_stall_full;
   logic csr_stall;
   logic intr_hold;
   logic intr;

   ////////////////////
   // interrupt
   ////////////////////

   // waits for a valid instruction in e since bubbles cannot take it
   assign intr = issue.valid & (timer_intr | intr_hold);

   always_ff @(posedge clk) begin
      if (rst) begin
         intr_hold <= 1'b0;
      end else if (timer_intr | issue.valid) begin
         // clears once the interrupt is taken
         intr_hold <= timer_intr & ~issue.valid;
      end
   end

   assign except = intr;
   assign kill   = intr;

   ////////////////////
   // lsu stall
   ////////////////////

   assign lsu_valid_e = issue.lsu_valid & ~kill;

   // starts with the request, ends on finish
   always_ff @(posedge clk) begin
      if (rst) begin
         lsu_stall <= 1'b0;
      end else begin
         lsu_stall <= lsu_valid_e | (lsu_stall & ~lsu_finish);
      end
   end

   assign lsu_stall_full = lsu_stall | lsu_valid_e;

   ////////////////////
   // csr stall
   ////////////////////

   // write in e, then the staged write at m
   assign csr_stall = issue.csr_wen | csr_wen_m;

   assign stall_req = lsu_stall_full | csr_stall;

   // a finish only answers an outstanding request
   assert property (@(posedge clk) disable iff (rst)
      lsu_finish |-> lsu_stall);

endmodule

/* ecl_top.sv */
`timescale 1ns/1ps

module ecl_top (
   input  logic              clk,
   input  logic              rst,
   input  ecl_pkg::issue_t   issue,
   input  ecl_pkg::word_t    alu_a_raw,
   input  ecl_pkg::word_t    alu_b_raw,
   input  ecl_pkg::word_t    imm_shifted,
   input  ecl_pkg::word_t    alu_res_e,
   input  ecl_pkg::word_t    mul_res_m,
   input  ecl_pkg::csr_addr_t csr_raddr_d,
   input  ecl_pkg::word_t    csr_rdata_d,
   input  ecl_pkg::lsu_ret_t lsu_ret,
   input  logic              timer_intr,
   output ecl_pkg::word_t    alu_a,
   output ecl_pkg::word_t    alu_b,
   output logic              lsu_valid_e,
   output ecl_pkg::word_t    lsu_base,
   output ecl_pkg::word_t    lsu_offset,
   output ecl_pkg::word_t    lsu_wdata,
   output ecl_pkg::word_t    mul_a,
   output ecl_pkg::word_t    mul_b,
   output ecl_pkg::csr_addr_t csr_raddr_out,
   output ecl_pkg::csr_wr_t  csr_wr,
   output ecl_pkg::rf_wr_t   irf_wr,
   output logic              stall_req,
   output logic              except
);

   import ecl_pkg::*;

   word_t  rs1_data;
   word_t  rs2_data;
   word_t  csr_rdata_m;
   rf_wr_t fwd_m;
   rf_wr_t alu_m;
   logic   mul_valid_m;
   logic   mul_wen_m;
   logic   csr_valid_m;
   logic   csr_rdwen_m;
   logic   kill;

   // forwarded operands feed every unit
   assign alu_a         = rs1_data;
   assign alu_b         = rs2_data;
   assign lsu_base      = rs1_data;
   assign lsu_wdata     = rs2_data;
   assign mul_a         = rs1_data;
   assign mul_b         = rs2_data;
   assign csr_raddr_out = csr_raddr_d;

   ecl_bypass u_bypass (
      .issue       (issue),
      .alu_a_raw   (alu_a_raw),
      .alu_b_raw   (alu_b_raw),
      .imm_shifted (imm_shifted),
      .fwd_m       (fwd_m),
      .fwd_w       (irf_wr),
      .rs1_data    (rs1_data),
      .rs2_data    (rs2_data),
      .lsu_offset  (lsu_offset)
   );

   ecl_e2m_regs u_e2m_regs (
      .clk         (clk),
      .rst         (rst),
      .issue       (issue),
      .kill        (kill),
      .rs1_data    (rs1_data),
      .rs2_data    (rs2_data),
      .alu_res_e   (alu_res_e),
      .csr_rdata_d (csr_rdata_d),
      .alu_m       (alu_m),
      .mul_valid_m (mul_valid_m),
      .mul_wen_m   (mul_wen_m),
      .csr_valid_m (csr_valid_m),
      .csr_rdwen_m (csr_rdwen_m),
      .csr_rdata_m (csr_rdata_m),
      .csr_wr      (csr_wr)
   );

   ecl_writeback u_writeback (
      .clk         (clk),
      .rst         (rst),
      .alu_m       (alu_m),
      .mul_valid_m (mul_valid_m),
      .mul_wen_m   (mul_wen_m),
      .csr_valid_m (csr_valid_m),
      .csr_rdwen_m (csr_rdwen_m),
      .csr_rdata_m (csr_rdata_m),
      .mul_res_m   (mul_res_m),
      .lsu_ret     (lsu_ret),
      .fwd_m       (fwd_m),
      .irf_wr      (irf_wr)
   );

   ecl_stall_intr u_stall_intr (
      .clk         (clk),
      .rst         (rst),
      .issue       (issue),
      .csr_wen_m   (csr_wr.wen),
      .lsu_finish  (lsu_ret.finish),
      .timer_intr  (timer_intr),
      .lsu_valid_e (lsu_valid_e),
      .kill        (kill),
      .except      (except),
      .stall_req   (stall_req)
   );

endmodule

/* tb_ecl.sv */
`timescale 1ns/1ps

module tb_ecl;

   import ecl_pkg::*;

   localparam int K_ALU = 0;
   localparam int K_MUL = 1;
   localparam int K_CSR = 2;
   localparam int K_LSU = 3;
   localparam int DRAIN_LIMIT = 16;

   logic      clk;
   logic      rst;
   issue_t    issue;
   word_t     alu_a_raw;
   word_t     alu_b_raw;
   word_t     imm_shifted;
   word_t     alu_res_e;
   word_t     mul_res_m;
   csr_addr_t csr_raddr_d;
   word_t     csr_rdata_d;
   lsu_ret_t  lsu_ret;
   logic      timer_intr;
   word_t     alu_a;
   word_t     alu_b;
   logic      lsu_valid_e;
   word_t     lsu_base;
   word_t     lsu_offset;
   word_t     lsu_wdata;
   word_t     mul_a;
   word_t     mul_b;
   csr_addr_t csr_raddr_out;
   csr_wr_t   csr_wr;
   rf_wr_t    irf_wr;
   logic      stall_req;
   logic      except;

   // regfile as written by the DUT, and the value each register should hold
   word_t     rf_model [0:31];
   word_t     shadow [0:31];
   word_t     csr_mem [0:15];
   rf_wr_t    exp_q [$];
   int        due_q [$];
   csr_wr_t   exp_csr;
   csr_wr_t   pend_csr;
   csr_addr_t csr_sel;
   csr_addr_t raddr_prev;
   logic      exp_stall;
   logic      csr_prev;
   logic      lsu_prev;
   logic      fin_prev;
   logic      lsu_busy;
   logic      hold_model;
   int        cyc;
   int        errors;
   int        tests;
   int        seed;

   ecl_top u_dut (
      .clk           (clk),
      .rst           (rst),
      .issue         (issue),
      .alu_a_raw     (alu_a_raw),
      .alu_b_raw     (alu_b_raw),
      .imm_shifted   (imm_shifted),
      .alu_res_e     (alu_res_e),
      .mul_res_m     (mul_res_m),
      .csr_raddr_d   (csr_raddr_d),
      .csr_rdata_d   (csr_rdata_d),
      .lsu_ret       (lsu_ret),
      .timer_intr    (timer_intr),
      .alu_a         (alu_a),
      .alu_b         (alu_b),
      .lsu_valid_e   (lsu_valid_e),
      .lsu_base      (lsu_base),
      .lsu_offset    (lsu_offset),
      .lsu_wdata     (lsu_wdata),
      .mul_a         (mul_a),
      .mul_b         (mul_b),
      .csr_raddr_out (csr_raddr_out),
      .csr_wr        (csr_wr),
      .irf_wr        (irf_wr),
      .stall_req     (stall_req),
      .except        (except)
   );

   ////////////////////
   // unit models
   ////////////////////

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   assign alu_res_e   = alu_a + alu_b;
   assign csr_rdata_d = csr_mem[csr_raddr_out[3:0]];

   always @(posedge clk) begin
      mul_res_m <= mul_a * mul_b;
      cyc       <= cyc + 1;
   end

   // write lands mid cycle, so the next read already sees it
   always @(negedge clk) begin
      if (irf_wr.wen) begin
         rf_model[irf_wr.rd] = irf_wr.data;
      end
   end

   ////////////////////
   // reference and compare
   ////////////////////

   function automatic rf_wr_t ref_write(input int kind, input reg_addr_t rd, input word_t a,
                                        input word_t b, input word_t csr_val,
                                        input lsu_ret_t ret);
      rf_wr_t w;
      w.wen = 1'b1;
      w.rd  = (kind == K_LSU) ? ret.rd : rd;
      case (kind)
         K_MUL:   w.data = a * b;
         K_CSR:   w.data = csr_val;
         K_LSU:   w.data = ret.rdata;
         default: w.data = a + b;
      endcase
      return w;
   endfunction

   task automatic check_rf(input rf_wr_t got, input rf_wr_t exp);
      if (got !== exp) begin
         $display("Fail irf_wr: got %h expected %h", got, exp);
         errors++;
      end
   endtask

   task automatic check_csr(input csr_wr_t got, input csr_wr_t exp);
      if (got !== exp) begin
         $display("Fail csr_wr: got %h expected %h", got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   always @(negedge clk) begin
      if (!rst) begin
         if (due_q.size() > 0 && due_q[0] < cyc) begin
            $display("register write to r%0d never appeared", exp_q[0].rd);
            errors++;
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
         end
         if (irf_wr.wen) begin
            if (due_q.size() > 0 && due_q[0] == cyc) begin
               check_rf(irf_wr, exp_q.pop_front());
               void'(due_q.pop_front());
            end else begin
               $display("unexpected register write to r%0d", irf_wr.rd);
               errors++;
            end
         end
         check_bit("stall_req", stall_req, exp_stall);
         if (exp_csr.wen) begin
            check_csr(csr_wr, exp_csr);
         end else begin
            check_bit("csr_wr.wen", csr_wr.wen, 1'b0);
         end
      end
   end

   ////////////////////
   // stimulus
   ////////////////////

   function automatic reg_addr_t rand_reg();
      return reg_addr_t'($random(seed));
   endfunction

   function automatic issue_t make_op(input int kind, input reg_addr_t rs1,
                                      input reg_addr_t rs2, input reg_addr_t rd,
                                      input logic b_imm);
      issue_t op;
      op           = '0;
      op.valid     = 1'b1;
      op.rs1       = rs1;
      op.rs2       = rs2;
      op.rf_target = rd;
      op.b_imm     = b_imm;
      case (kind)
         K_MUL: begin
            op.mul_valid = 1'b1;
            op.mul_wen   = 1'b1;
         end
         K_CSR: begin
            op.csr_valid = 1'b1;
            op.csr_rdwen = 1'b1;
         end
         K_LSU:   op.lsu_valid = 1'b1;
         default: op.alu_wen   = 1'b1;
      endcase
      return op;
   endfunction

   // drives one cycle in e and queues the expected results
   task automatic drive_cycle(input issue_t op, input word_t imm, input logic timer,
                              input lsu_ret_t ret);
      word_t  a_exp;
      word_t  b_exp;
      word_t  csr_val;
      logic   fire;
      logic   lv;
      int     kind;
      rf_wr_t w;
      @(posedge clk);
      a_exp   = shadow[op.rs1];
      b_exp   = op.b_imm ? imm : shadow[op.rs2];
      csr_val = csr_mem[raddr_prev[3:0]];
      fire    = op.valid & (timer | hold_model);
      lv      = op.lsu_valid & ~fire;
      kind    = op.mul_valid ? K_MUL : (op.csr_valid ? K_CSR : K_ALU);
      if (op.valid) begin
         hold_model = 1'b0;
      end else if (timer) begin
         hold_model = 1'b1;
      end
      issue       <= op;
      alu_a_raw   <= rf_model[op.rs1];
      alu_b_raw   <= op.b_imm ? imm : rf_model[op.rs2];
      imm_shifted <= imm;
      csr_raddr_d <= csr_sel;
      timer_intr  <= timer;
      lsu_ret     <= ret;
      raddr_prev  = csr_sel;
      // load result is due a cycle earlier than the instruction in e
      if (ret.finish && ret.wen) begin
         w = ref_write(K_LSU, '0, '0, '0, '0, ret);
         exp_q.push_back(w);
         due_q.push_back(cyc + 2);
         shadow[w.rd] = w.data;
      end
      if (op.valid && !fire && (op.alu_wen || op.mul_wen || op.csr_rdwen)) begin
         w = ref_write(kind, op.rf_target, a_exp, b_exp, csr_val, ret);
         exp_q.push_back(w);
         due_q.push_back(cyc + 3);
         shadow[w.rd] = w.data;
      end
      exp_csr        <= pend_csr;
      pend_csr.wen   = op.csr_wen;
      pend_csr.waddr = op.csr_waddr;
      pend_csr.wdata = b_exp;
      pend_csr.mask  = op.csr_xchg ? a_exp : 32'hffff_ffff;
      lsu_busy       = lsu_prev | (lsu_busy & ~fin_prev);
      exp_stall      <= op.csr_wen | csr_prev | lv | lsu_busy;
      lsu_prev       = lv;
      fin_prev       = ret.finish;
      csr_prev       = op.csr_wen;
      @(negedge clk);
      check_bit("except", except, fire);
      check_bit("lsu_valid_e", lsu_valid_e, lv);
      if (op.valid) begin
         check_word("alu_a", alu_a, a_exp);
         check_word("alu_b", alu_b, b_exp);
      end
      if (op.valid && op.mul_valid) begin
         check_word("mul_a", mul_a, a_exp);
         check_word("mul_b", mul_b, b_exp);
      end
      if (lv) begin
         check_word("lsu_base", lsu_base, a_exp);
         check_word("lsu_offset", lsu_offset, imm);
         check_word("lsu_wdata", lsu_wdata, b_exp);
      end
   endtask

   task automatic bubble(input logic timer, input lsu_ret_t ret);
      drive_cycle('0, '0, timer, ret);
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (due_q.size() > 0 && n < DRAIN_LIMIT) begin
         bubble(1'b0, '0);
         n++;
      end
      if (due_q.size() > 0) begin
         $display("timeout with %0d register writes still pending", due_q.size());
         errors++;
      end
      bubble(1'b0, '0);
      bubble(1'b0, '0);
   endtask

   task automatic report(input string name, input int start);
      if (errors == start) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - start);
      end
      tests++;
   endtask

   initial begin
      int        i;
      int        start;
      int        delay;
      reg_addr_t prev1;
      reg_addr_t prev2;
      reg_addr_t rd;
      issue_t    op;
      lsu_ret_t  ret;
      seed        = 49;
      errors      = 0;
      tests       = 0;
      cyc         = 0;
      rst         = 1'b1;
      issue       = '0;
      alu_a_raw   = '0;
      alu_b_raw   = '0;
      imm_shifted = '0;
      mul_res_m   = '0;
      csr_raddr_d = '0;
      lsu_ret     = '0;
      timer_intr  = 1'b0;
      exp_csr     = '0;
      pend_csr    = '0;
      csr_sel     = '0;
      raddr_prev  = '0;
      exp_stall   = 1'b0;
      csr_prev    = 1'b0;
      lsu_prev    = 1'b0;
      fin_prev    = 1'b0;
      lsu_busy    = 1'b0;
      hold_model  = 1'b0;
      for (i = 0; i < 32; i++) begin
         rf_model[i] = $random(seed);
         shadow[i]   = rf_model[i];
      end
      for (i = 0; i < 16; i++) begin
         csr_mem[i] = 32'h5a5a_0000 + i * 32'h0003_0107;
      end
      repeat (16) @(posedge clk);
      rst <= 1'b0;

      start = errors;
      for (i = 0; i < 20; i++) begin
         drive_cycle(make_op(K_ALU, rand_reg(), rand_reg(), rand_reg(), 1'b0), '0, 1'b0, '0);
      end
      drain();
      report("alu write", start);

      // rs1 hits the m stage, rs2 the w stage
      start = errors;
      prev1 = rand_reg();
      prev2 = rand_reg();
      for (i = 0; i < 12; i++) begin
         rd = rand_reg();
         op = make_op(K_ALU, prev1, prev2, rd, (i % 4) == 3);
         drive_cycle(op, $random(seed), 1'b0, '0);
         prev2 = prev1;
         prev1 = rd;
      end
      drain();
      report("forwarding", start);

      start   = errors;
      csr_sel = 14'd5;
      bubble(1'b0, '0);
      drive_cycle(make_op(K_CSR, rand_reg(), rand_reg(), rand_reg(), 1'b0), '0, 1'b0, '0);
      bubble(1'b0, '0);
      op           = make_op(K_CSR, rand_reg(), rand_reg(), rand_reg(), 1'b0);
      op.csr_wen   = 1'b1;
      op.csr_xchg  = 1'b1;
      op.csr_waddr = csr_sel;
      drive_cycle(op, '0, 1'b0, '0);
      bubble(1'b0, '0);
      csr_sel = 14'd9;
      bubble(1'b0, '0);
      op           = make_op(K_CSR, rand_reg(), rand_reg(), rand_reg(), 1'b0);
      op.csr_wen   = 1'b1;
      op.csr_waddr = csr_sel;
      drive_cycle(op, '0, 1'b0, '0);
      bubble(1'b0, '0);
      drain();
      report("csr access", start);

      start = errors;
      for (i = 0; i < 3; i++) begin
         drive_cycle(make_op(K_LSU, rand_reg(), '0, '0, 1'b1), $random(seed), 1'b0, '0);
         delay = ($unsigned($random(seed)) % 6) + 1;
         repeat (delay) bubble(1'b0, '0);
         ret        = '0;
         ret.rdata  = $random(seed);
         ret.finish = 1'b1;
         ret.rd     = rand_reg();
         ret.wen    = 1'b1;
         bubble(1'b0, ret);
         drain();
      end
      report("load", start);

      start = errors;
      for (i = 0; i < 8; i++) begin
         drive_cycle(make_op(K_MUL, rand_reg(), rand_reg(), rand_reg(), 1'b0), '0, 1'b0, '0);
      end
      drain();
      report("multiply", start);

      // interrupt seen in a bubble waits for the next valid instruction
      start = errors;
      bubble(1'b1, '0);
      bubble(1'b0, '0);
      drive_cycle(make_op(K_ALU, rand_reg(), rand_reg(), rand_reg(), 1'b0), '0, 1'b0, '0);
      drive_cycle(make_op(K_ALU, rand_reg(), rand_reg(), rand_reg(), 1'b0), '0, 1'b0, '0);
      drain();
      report("interrupt", start);

      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* build.f */
+incdir+.
ecl_pkg.sv
ecl_bypass.sv
ecl_e2m_regs.sv
ecl_writeback.sv
ecl_stall_intr.sv
ecl_top.sv
tb_ecl.sv
